/* bench/sprite_ppu_checker.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

module sprite_ppu_checker (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire ppu_cfg_pkg::layer_cfg_t cfg,
	input  wire                          line_start,
	input  wire [`W_COORD-1:0]           beam_y,
	input  wire                          beam_step,
	input  wire                          pixel_vld,
	input  wire ppu_bus_pkg::pixel_t     pixel,
	input  logic [`W_DATA-1:0]           mem [256],
	output logic [31:0]                  err_count,
	output logic [31:0]                  check_count
);
	timeunit 1ns;
	timeprecision 1ps;

	string               test_name;
	logic [`W_COORD-1:0] line_y;
	int                  x;
	int                  step_x;
	logic                step_seen;
	logic [7:0]          exp_pix;
	logic [7:0]          act_pix;

	task automatic begin_test(input string name);
		test_name = name;
	endtask

	// {valid, index, value} of the front sprite at beam position px
	function automatic logic [7:0] predict(input int px);
		int          v;
		int          u;
		int          bpp;
		int          byte_addr;
		logic [31:0] word;
		logic [3:0]  val;
		predict = 8'h00;
		bpp = 1 << cfg.pixmode;
		for (int s = 0; s < `N_SPRITE; s++) begin
			v = int'(line_y) - int'(cfg.sprite[s].pos_y);
			u = px - int'(cfg.sprite[s].pos_x);
			if (!predict[7] && v >= 0 && v < `TILE_W && u >= 0 && u < `TILE_W) begin
				byte_addr = int'(cfg.tsbase) * 256
					+ ((int'(cfg.sprite[s].tile) * 64 + v * 8) * bpp) / 8;
				word = mem[(byte_addr / 4) % 256];
				val = 4'((word >> ((byte_addr % 4) * 8 + u * bpp)) & ((1 << bpp) - 1));
				if (val != 4'h0)
					predict = {1'b1, 3'(s), val}; // a transparent pixel lets later sprites through
			end
		end
	endfunction

	always @(posedge clk) begin
		step_seen <= beam_step;
		step_x <= x;
		if (line_start) begin
			line_y <= beam_y;
			x <= 0;
		end else if (beam_step) begin
			x <= x + 1;
		end
	end

	// the output registered at the step edge is stable by the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			err_count = 0;
			check_count = 0;
		end else if (step_seen) begin
			exp_pix = predict(step_x);
			act_pix = pixel_vld ? {1'b1, pixel} : 8'h00;
			check_count++;
			if (act_pix !== exp_pix) begin
				err_count++;
				$display("ERR %s x=%0d expected %h actual %h", test_name, step_x, exp_pix, act_pix);
			end
		end
	end

endmodule

`default_nettype wire

/* bench/sprite_ppu_tb.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

module sprite_ppu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_TEST = 8;
	localparam int N_STEP = 64;

	typedef struct packed {
		ppu_cfg_pkg::layer_cfg_t cfg;
		logic [`W_COORD-1:0]     beam_y;
		logic [3:0]              exp_fetches; // sprites that cross the line
	} line_test_t;

	line_test_t              tests [N_TEST];
	string                   test_names [N_TEST];
	logic                    clk;
	logic                    rst_n;
	ppu_cfg_pkg::layer_cfg_t cfg;
	logic                    line_start;
	logic [`W_COORD-1:0]     beam_y;
	logic                    beam_step;
	logic                    bus_vld;
	logic [`W_ADDR-1:0]      bus_addr;
	logic                    bus_rdy;
	logic [`W_DATA-1:0]      bus_data;
	logic                    line_ready;
	logic                    pixel_vld;
	ppu_bus_pkg::pixel_t     pixel;
	logic [`W_DATA-1:0]      mem [256];
	logic [31:0]             lcg_state;
	logic                    mem_busy;
	int                      mem_delay;
	int                      fetch_total;
	logic [31:0]             err_count;
	logic [31:0]             check_count;
	int                      tb_errors;
	logic                    timed_out;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	sprite_ppu dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.line_start (line_start),
		.beam_y     (beam_y),
		.beam_step  (beam_step),
		.bus_vld    (bus_vld),
		.bus_addr   (bus_addr),
		.bus_rdy    (bus_rdy),
		.bus_data   (bus_data),
		.line_ready (line_ready),
		.pixel_vld  (pixel_vld),
		.pixel      (pixel)
	);

	sprite_ppu_checker chk (
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg         (cfg),
		.line_start  (line_start),
		.beam_y      (beam_y),
		.beam_step   (beam_step),
		.pixel_vld   (pixel_vld),
		.pixel       (pixel),
		.mem         (mem),
		.err_count   (err_count),
		.check_count (check_count)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic ppu_cfg_pkg::sprite_attr_t place(input int px, input int py, input int tile);
		ppu_cfg_pkg::sprite_attr_t a;
		a.pos_x = `W_COORD'(px);
		a.pos_y = `W_COORD'(py);
		a.tile = 8'(tile);
		return a;
	endfunction

	function automatic line_test_t new_line(input int base, input ppu_cfg_pkg::pixmode_e mode,
		input int y, input int fetches);
		line_test_t l;
		l = '0;
		for (int s = 0; s < `N_SPRITE; s++)
			l.cfg.sprite[s] = place(0, 1000, s); // parked well below any tested beam row
		l.cfg.tsbase = 8'(base);
		l.cfg.pixmode = mode;
		l.beam_y = `W_COORD'(y);
		l.exp_fetches = 4'(fetches);
		return l;
	endfunction

	task automatic build_table();
		test_names[0] = "bpp1_single";
		tests[0] = new_line(1, ppu_cfg_pkg::PIX_1BPP, 102, 1);
		tests[0].cfg.sprite[0] = place(5, 100, 3);
		test_names[1] = "bpp2_single";
		tests[1] = new_line(2, ppu_cfg_pkg::PIX_2BPP, 205, 1);
		tests[1].cfg.sprite[0] = place(10, 200, 7);
		test_names[2] = "bpp4_single";
		tests[2] = new_line(0, ppu_cfg_pkg::PIX_4BPP, 53, 1);
		tests[2].cfg.sprite[0] = place(20, 50, 5);
		// rows 0 and 7 show, 8 above and 8 below do not
		test_names[3] = "vertical_range";
		tests[3] = new_line(0, ppu_cfg_pkg::PIX_2BPP, 300, 2);
		tests[3].cfg.sprite[0] = place(0, 300, 1);
		tests[3].cfg.sprite[1] = place(16, 293, 2);
		tests[3].cfg.sprite[2] = place(32, 292, 3);
		tests[3].cfg.sprite[3] = place(48, 308, 4);
		test_names[4] = "horizontal_edges";
		tests[4] = new_line(3, ppu_cfg_pkg::PIX_4BPP, 10, 4);
		tests[4].cfg.sprite[0] = place(0, 5, 9);
		tests[4].cfg.sprite[1] = place(56, 3, 10);
		tests[4].cfg.sprite[2] = place(64, 9, 11);
		tests[4].cfg.sprite[3] = place(500, 9, 12);
		test_names[5] = "overlap_1bpp";
		tests[5] = new_line(1, ppu_cfg_pkg::PIX_1BPP, 40, 3);
		tests[5].cfg.sprite[0] = place(4, 40, 20);
		tests[5].cfg.sprite[1] = place(6, 35, 21);
		tests[5].cfg.sprite[2] = place(8, 33, 22);
		test_names[6] = "all_eight_4bpp";
		tests[6] = new_line(2, ppu_cfg_pkg::PIX_4BPP, 77, 8);
		test_names[7] = "all_eight_2bpp";
		tests[7] = new_line(0, ppu_cfg_pkg::PIX_2BPP, 500, 8);
		for (int s = 0; s < `N_SPRITE; s++) begin
			tests[6].cfg.sprite[s] = place(s * 7, 77 - s, s * 3);
			tests[7].cfg.sprite[s] = place(s * 4, 493 + s, 40 + s);
		end
	endtask

	// tile memory answers each read after 0 to 3 cycles
	initial begin
		bus_rdy = 1'b0;
		bus_data = '0;
		mem_busy = 1'b0;
		mem_delay = 0;
		fetch_total = 0;
		forever begin
			@(posedge clk);
			#2;
			if (bus_rdy) begin
				fetch_total++; // the transfer completed on this edge
				bus_rdy = 1'b0;
				mem_busy = 1'b0;
			end
			if (bus_vld && !mem_busy) begin
				mem_busy = 1'b1;
				mem_delay = int'(lcg_next() >> 16) % 4;
			end
			if (mem_busy) begin
				if (mem_delay == 0) begin
					bus_rdy = 1'b1;
					bus_data = mem[bus_addr[9:2]];
				end else begin
					mem_delay--;
				end
			end
		end
	end

	initial begin
		int wait_cycles;
		int errs_before;
		int checks_before;
		int fetch_before;
		int fetch_errs;
		int tests_run;
		line_start = 1'b0;
		beam_step = 1'b0;
		beam_y = '0;
		cfg = '0;
		tb_errors = 0;
		tests_run = 0;
		timed_out = 1'b0;
		lcg_state = 32'd48728;
		for (int a = 0; a < 256; a++)
			mem[a] = lcg_next();
		build_table();
		for (wait_cycles = 0; wait_cycles < 20 && !rst_n; wait_cycles++)
			@(posedge clk);
		if (!rst_n) begin
			$display("reset was never released");
			timed_out = 1'b1;
		end
		@(posedge clk);
		#2;
		for (int t = 0; t < N_TEST && !timed_out; t++) begin
			chk.begin_test(test_names[t]);
			errs_before = err_count;
			checks_before = check_count;
			fetch_before = fetch_total;
			fetch_errs = 0;
			cfg = tests[t].cfg;
			beam_y = tests[t].beam_y;
			line_start = 1'b1;
			@(posedge clk);
			#2;
			line_start = 1'b0;
			for (wait_cycles = 0; wait_cycles < 500 && !line_ready; wait_cycles++) begin
				@(posedge clk);
				#2;
			end
			if (!line_ready) begin
				$display("timeout: line_ready never rose in test %s", test_names[t]);
				timed_out = 1'b1;
			end else begin
				if (fetch_total - fetch_before != int'(tests[t].exp_fetches)) begin
					fetch_errs = 1;
					$display("ERR %s fetches expected %0d actual %0d", test_names[t],
						tests[t].exp_fetches, fetch_total - fetch_before);
				end
				for (int x = 0; x < N_STEP; x++) begin
					beam_step = 1'b1;
					@(posedge clk);
					#2;
				end
				beam_step = 1'b0;
				@(posedge clk); // lets the last pixel be checked
				#2;
				tb_errors += fetch_errs;
				tests_run++;
				$display("test %s: %0d pixels checked, %0d errors", test_names[t],
					check_count - checks_before, err_count - errs_before + fetch_errs);
			end
		end
		$display("tests %0d of %0d, pixel checks %0d, errors %0d", tests_run, N_TEST,
			check_count, err_count + tb_errors);
		if (tb_errors == 0 && err_count == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* design/ppu_bus_pkg.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

package ppu_bus_pkg;

	// answer to a coordinate query, taken against x = 0
	typedef struct packed {
		logic                on_line;
		logic [`W_COORD-1:0] precount;  // beam steps before the first pixel
		logic [3:0]          postcount; // pixels still to show
	} span_t;

	typedef struct packed {
		logic [`W_DATA-1:0] data;
		logic [4:0]         offset; // bit position of the row inside the word
	} fetch_rsp_t;

	// value 0 is transparent
	typedef struct packed {
		logic [$clog2(`N_SPRITE)-1:0] index;
		logic [3:0]                   value;
	} pixel_t;

endpackage

`default_nettype wire

/* design/ppu_cfg_pkg.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

package ppu_cfg_pkg;

	// coded as log2 of the bits per pixel
	typedef enum logic [1:0] {
		PIX_1BPP = 2'd0,
		PIX_2BPP = 2'd1,
		PIX_4BPP = 2'd2
	} pixmode_e;

	typedef struct packed {
		logic [`W_COORD-1:0] pos_x;
		logic [`W_COORD-1:0] pos_y;
		logic [7:0]          tile;
	} sprite_attr_t;

	typedef struct packed {
		sprite_attr_t [`N_SPRITE-1:0] sprite;
		logic [7:0]                   tsbase; // tileset base in 256-byte units
		pixmode_e                     pixmode; // shared by every sprite of the layer
	} layer_cfg_t;

endpackage

`default_nettype wire

/* design/sprite_agu.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

module sprite_agu (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire ppu_cfg_pkg::layer_cfg_t cfg,
	input  wire [`W_COORD-1:0]           beam_y,

	input  wire [`N_SPRITE-1:0]          qry_req,
	output logic [`N_SPRITE-1:0]         qry_ack,
	output ppu_bus_pkg::span_t           span,

	input  wire [`N_SPRITE-1:0]          fetch_vld,
	output logic [`N_SPRITE-1:0]         fetch_rdy,
	output ppu_bus_pkg::fetch_rsp_t      fetch_rsp,

	output logic                         bus_vld,
	output logic [`W_ADDR-1:0]           bus_addr,
	input  wire                          bus_rdy,
	input  wire [`W_DATA-1:0]            bus_data
);

	ppu_cfg_pkg::sprite_attr_t q_attr;
	logic [`W_COORD-1:0]       q_v;

	ppu_cfg_pkg::sprite_attr_t f_attr;
	logic [`N_SPRITE-1:0]      f_pend;
	logic [`N_SPRITE-1:0]      f_pick;
	logic [`N_SPRITE-1:0]      f_gnt;
	logic [`W_COORD-1:0]       f_v;
	logic [13:0]               f_pix_idx;
	logic [15:0]               f_bit_addr;
	logic [`W_ADDR-1:0]        f_byte_addr;

	// queries are answered in the cycle they are granted, lowest index first
	assign qry_ack = qry_req & (~qry_req + 1'b1);

	always_comb begin
		q_attr = '0;
		for (int i = 0; i < `N_SPRITE; i++) begin
			if (qry_ack[i])
				q_attr = cfg.sprite[i];
		end
	end

	assign q_v = beam_y - q_attr.pos_y; // rows above the sprite wrap to large values
	assign span.on_line = q_v < `TILE_W;
	assign span.precount = q_attr.pos_x;
	assign span.postcount = 4'(`TILE_W);

	// the engine being served this cycle must not win the next grant
	assign f_pend = fetch_vld & ~fetch_rdy;
	assign f_pick = f_pend & (~f_pend + 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			f_gnt <= '0;
		else if (bus_rdy || !bus_vld)
			f_gnt <= f_pick; // grant is held until the bus accepts
	end

	always_comb begin
		f_attr = '0;
		for (int i = 0; i < `N_SPRITE; i++) begin
			if (f_gnt[i])
				f_attr = cfg.sprite[i];
		end
	end

	assign f_v = beam_y - f_attr.pos_y;
	assign f_pix_idx = {f_attr.tile, f_v[2:0], 3'b000}; // tile*64 + v*8
	assign f_bit_addr = {2'b00, f_pix_idx} << cfg.pixmode;
	assign f_byte_addr = {cfg.tsbase, 8'h00} + f_bit_addr[15:3];

	assign bus_vld = |f_gnt;
	assign bus_addr = {f_byte_addr[`W_ADDR-1:2], 2'b00};

	assign fetch_rdy = f_gnt & {`N_SPRITE{bus_rdy}};
	assign fetch_rsp.data = bus_data;
	assign fetch_rsp.offset = {f_byte_addr[1:0], 3'b000};

	// the held grant points at exactly one engine that is still asking
	a_fetch_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		bus_vld |-> $onehot(f_gnt & fetch_vld));

	// cfg and beam_y come from the top level and must hold for the whole transfer
	a_bus_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		bus_vld && !bus_rdy |=> bus_vld && $stable(bus_addr));

endmodule

`default_nettype wire

/* design/sprite_compositor.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

module sprite_compositor (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire [`N_SPRITE-1:0][3:0] pix_values,
	input  wire                     beam_step,
	output logic                    pixel_vld,
	output ppu_bus_pkg::pixel_t     pixel
);

	ppu_bus_pkg::pixel_t pick;
	logic                hit;

	always_comb begin
		pick = '0;
		hit = 1'b0;
		// walking downwards leaves the lowest opaque index in pick
		for (int i = `N_SPRITE - 1; i >= 0; i--) begin
			if (pix_values[i] != 4'h0) begin
				hit = 1'b1;
				pick.index = i[$clog2(`N_SPRITE)-1:0];
				pick.value = pix_values[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pixel_vld <= 1'b0;
		else
			pixel_vld <= beam_step && hit; // one pixel per beam step
	end

	always_ff @(posedge clk) begin
		if (beam_step)
			pixel <= pick;
	end

endmodule

`default_nettype wire

/* design/sprite_engine.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

module sprite_engine (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          line_start,
	input  wire                          beam_step,

	output logic                         qry_req,
	input  wire                          qry_ack,
	input  wire ppu_bus_pkg::span_t      span,

	output logic                         fetch_vld,
	input  wire                          fetch_rdy,
	input  wire ppu_bus_pkg::fetch_rsp_t fetch_rsp,

	input  wire ppu_cfg_pkg::pixmode_e   pixmode,
	output logic                         done,
	output logic [3:0]                   pix_value
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_QUERY,
		ST_FETCH,
		ST_WAIT,
		ST_SHIFT
	} state_e;

	state_e              state;
	logic [`W_COORD-1:0] precount;
	logic [3:0]          postcount;
	logic [`W_DATA-1:0]  row;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			precount <= '0;
			postcount <= '0;
		end else if (line_start) begin
			state <= ST_QUERY;
		end else begin
			case (state)
				ST_QUERY: begin
					if (qry_ack) begin
						precount <= span.precount;
						postcount <= span.postcount;
						state <= span.on_line ? ST_FETCH : ST_IDLE;
					end
				end
				ST_FETCH: begin
					if (fetch_rdy)
						state <= (precount == '0) ? ST_SHIFT : ST_WAIT;
				end
				ST_WAIT: begin
					if (beam_step) begin
						precount <= precount - 1'b1;
						if (precount == `W_COORD'(1))
							state <= ST_SHIFT; // next step lands on pos_x
					end
				end
				ST_SHIFT: begin
					if (beam_step) begin
						postcount <= postcount - 1'b1;
						if (postcount == 4'd1)
							state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// pixel u sits at bit u*bpp once the row is aligned
	always_ff @(posedge clk) begin
		if (state == ST_FETCH && fetch_rdy)
			row <= fetch_rsp.data >> fetch_rsp.offset;
		else if (state == ST_SHIFT && beam_step)
			row <= row >> (1 << pixmode);
	end

	always_comb begin
		pix_value = 4'h0;
		if (state == ST_SHIFT) begin
			case (pixmode)
				ppu_cfg_pkg::PIX_1BPP: pix_value = {3'b000, row[0]};
				ppu_cfg_pkg::PIX_2BPP: pix_value = {2'b00, row[1:0]};
				default:               pix_value = row[3:0];
			endcase
		end
	end

	assign qry_req = state == ST_QUERY;
	assign fetch_vld = state == ST_FETCH;
	assign done = state == ST_IDLE || state == ST_WAIT || state == ST_SHIFT; // idle or loaded

	// the address unit must only answer an engine that is still asking
	a_rdy_only_when_vld: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_rdy |-> fetch_vld);

endmodule

`default_nettype wire

/* design/sprite_ppu.sv */
`default_nettype none
`include "sprite_ppu_consts.svh"

module sprite_ppu (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire ppu_cfg_pkg::layer_cfg_t cfg,
	input  wire                          line_start,
	input  wire [`W_COORD-1:0]           beam_y,
	input  wire                          beam_step,

	output logic                         bus_vld,
	output logic [`W_ADDR-1:0]           bus_addr,
	input  wire                          bus_rdy,
	input  wire [`W_DATA-1:0]            bus_data,

	output logic                         line_ready,
	output logic                         pixel_vld,
	output ppu_bus_pkg::pixel_t          pixel
);

	logic [`W_COORD-1:0]      line_y;
	logic [`N_SPRITE-1:0]     qry_req;
	logic [`N_SPRITE-1:0]     qry_ack;
	ppu_bus_pkg::span_t       span;
	logic [`N_SPRITE-1:0]     fetch_vld;
	logic [`N_SPRITE-1:0]     fetch_rdy;
	ppu_bus_pkg::fetch_rsp_t  fetch_rsp;
	logic [`N_SPRITE-1:0]     done;
	logic [`N_SPRITE-1:0][3:0] pix_values;

	always_ff @(posedge clk) begin
		if (line_start)
			line_y <= beam_y; // beam_y is only valid with the strobe
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			line_ready <= 1'b0;
		else
			line_ready <= !line_start && &done;
	end

	sprite_agu u_agu (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.beam_y    (line_y),
		.qry_req   (qry_req),
		.qry_ack   (qry_ack),
		.span      (span),
		.fetch_vld (fetch_vld),
		.fetch_rdy (fetch_rdy),
		.fetch_rsp (fetch_rsp),
		.bus_vld   (bus_vld),
		.bus_addr  (bus_addr),
		.bus_rdy   (bus_rdy),
		.bus_data  (bus_data)
	);

	for (genvar i = 0; i < `N_SPRITE; i++) begin : g_engine
		sprite_engine u_engine (
			.clk        (clk),
			.rst_n      (rst_n),
			.line_start (line_start),
			.beam_step  (beam_step),
			.qry_req    (qry_req[i]),
			.qry_ack    (qry_ack[i]),
			.span       (span),
			.fetch_vld  (fetch_vld[i]),
			.fetch_rdy  (fetch_rdy[i]),
			.fetch_rsp  (fetch_rsp),
			.pixmode    (cfg.pixmode),
			.done       (done[i]),
			.pix_value  (pix_values[i])
		);
	end

	sprite_compositor u_compositor (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix_values (pix_values),
		.beam_step  (beam_step),
		.pixel_vld  (pixel_vld),
		.pixel      (pixel)
	);

endmodule

`default_nettype wire

/* include/sprite_ppu_consts.svh */
`ifndef SPRITE_PPU_CONSTS_SVH
`define SPRITE_PPU_CONSTS_SVH

// sprite engines on one line
`define N_SPRITE 8

// beam coordinates and sprite positions
`define W_COORD 10

// tile memory bus
`define W_DATA 32
`define W_ADDR 16

`define TILE_W 8 // sprites are square, so this is also the height

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the sprite layer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sprite_ppu.f --top-module sprite_ppu_tb \
	--Mdir obj_dir -o sprite_ppu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sprite_ppu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0

/* sprite_ppu.f */
+incdir+include
design/ppu_cfg_pkg.sv
design/ppu_bus_pkg.sv
design/sprite_agu.sv
design/sprite_engine.sv
design/sprite_compositor.sv
design/sprite_ppu.sv
bench/tb_clock.sv
bench/sprite_ppu_checker.sv
bench/sprite_ppu_tb.sv
